// ==== rtl/pcie_rx_pkg.sv ====
// shared widths and beat structs for the receive data link layer
// frame verdict type and the CRC constants
`default_nettype none

package pcie_rx_pkg;

  localparam int DATA_W = 32;
  localparam int SEQ_W  = 12;

  // link input and TLP output beat
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic              last;
  } stream_beat_t;

  // DLLP output beat, keep marks the valid bytes
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [3:0]        keep;
    logic              last;
  } dllp_beat_t;

  typedef enum logic [1:0] {
    VERDICT_ACCEPT,
    VERDICT_DUPLICATE,
    VERDICT_DROP
  } rx_verdict_e;

  localparam logic [7:0]  DLLP_TYPE_ACK = 8'h00;

  // LCRC is CRC-32, DLLP CRC is CRC-16, both MSB first
  localparam logic [31:0] LCRC_POLY     = 32'h04C1_1DB7;
  localparam logic [31:0] LCRC_INIT     = 32'hFFFF_FFFF;
  localparam logic [15:0] DLLP_CRC_POLY = 16'h100B;

endpackage

`default_nettype wire

// ==== rtl/axis_skid_buffer.sv ====
// two-entry valid/ready register stage
// registered ready cuts the combinational path back to the source
`default_nettype none

module axis_skid_buffer #(
  parameter type payload_t = logic
) (
  input  wire      clk_i,
  input  wire      rst_i,
  input  wire      payload_t s_beat_i,
  input  wire      s_valid_i,
  output logic     s_ready_o,
  output payload_t m_beat_o,
  output logic     m_valid_o,
  input  wire      m_ready_i
);

  payload_t   entry_mem [2];
  logic       wr_ptr_r;
  logic       rd_ptr_r;
  logic [1:0] count_r;
  logic [1:0] count_next;
  logic       push;
  logic       pop;

  assign push       = s_valid_i && s_ready_o;
  assign pop        = m_valid_o && m_ready_i;
  assign count_next = count_r + {1'b0, push} - {1'b0, pop};
  assign m_valid_o  = (count_r != 2'd0);
  assign m_beat_o   = entry_mem[rd_ptr_r];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r  <= 1'b0;
      rd_ptr_r  <= 1'b0;
      count_r   <= 2'd0;
      s_ready_o <= 1'b0;
    end else begin
      wr_ptr_r  <= wr_ptr_r ^ push;
      rd_ptr_r  <= rd_ptr_r ^ pop;
      count_r   <= count_next;
      // stays high while one entry is spare, so full rate is kept
      s_ready_o <= (count_next != 2'd2);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_mem[wr_ptr_r] <= s_beat_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/lcrc_checker.sv ====
// running CRC-32 over the frame words
// match flag for the LCRC beat
`default_nettype none

module lcrc_checker (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          crc_clear_i,
  input  wire                          crc_step_i,
  input  wire [pcie_rx_pkg::DATA_W-1:0] word_i,
  output logic                         crc_match_o
);
  import pcie_rx_pkg::*;

  logic [DATA_W-1:0] crc_r;

  // one whole word, most significant bit first
  function automatic logic [DATA_W-1:0] crc32_step(input logic [DATA_W-1:0] crc,
                                                   input logic [DATA_W-1:0] word);
    logic [DATA_W-1:0] c;
    c = crc;
    for (int i = DATA_W - 1; i >= 0; i--) begin
      c = {c[DATA_W-2:0], 1'b0} ^ ((c[DATA_W-1] ^ word[i]) ? LCRC_POLY : '0);
    end
    return c;
  endfunction

  always_ff @(posedge clk_i) begin
    if (rst_i || crc_clear_i) begin
      crc_r <= LCRC_INIT;
    end else if (crc_step_i) begin
      crc_r <= crc32_step(crc_r, word_i);
    end
  end

  // word_i holds the LCRC beat while the FSM decides
  assign crc_match_o = (~crc_r == word_i);

endmodule

`default_nettype wire

// ==== rtl/rx_frame_counter.sv ====
// TLP dword counter of the current frame with oversize flag
// expected receive sequence number
`default_nettype none

module rx_frame_counter #(
  parameter int MAX_TLP_DW = 16
) (
  input  wire                         clk_i,
  input  wire                         rst_i,
  input  wire                         word_clear_i,
  input  wire                         word_step_i,
  input  wire                         seq_advance_i,
  output logic                        oversize_o,
  output logic [pcie_rx_pkg::SEQ_W-1:0] expected_seq_o
);

  // counts up to one past the limit and sticks there
  localparam int CNT_W = $clog2(MAX_TLP_DW + 2);

  logic [CNT_W-1:0] word_cnt_r;

  assign oversize_o = (word_cnt_r > CNT_W'(MAX_TLP_DW));

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      word_cnt_r <= '0;
    end else if (word_clear_i) begin
      word_cnt_r <= '0;
    end else if (word_step_i && !oversize_o) begin
      word_cnt_r <= word_cnt_r + 1'b1;
    end
  end

  // wraps at 4096 by its width
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      expected_seq_o <= '0;
    end else if (seq_advance_i) begin
      expected_seq_o <= expected_seq_o + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/dll_rx_fsm.sv ====
// frame receive FSM
// steers the buffer, the counters, the LCRC checker and the Ack request
`default_nettype none

module dll_rx_fsm (
  input  wire                           clk_i,
  input  wire                           rst_i,
  input  wire                           link_active_i,
  input  wire pcie_rx_pkg::stream_beat_t beat_i,
  input  wire                           beat_valid_i,
  output logic                          beat_ready_o,
  input  wire                           slot_free_i,
  output logic                          wr_en_o,
  output logic [pcie_rx_pkg::DATA_W-1:0] wr_data_o,
  output logic                          commit_o,
  output logic                          discard_o,
  output logic                          crc_clear_o,
  output logic                          crc_step_o,
  input  wire                           crc_match_i,
  output logic                          word_clear_o,
  output logic                          word_step_o,
  output logic                          seq_advance_o,
  input  wire                           oversize_i,
  input  wire [pcie_rx_pkg::SEQ_W-1:0]  expected_seq_i,
  output logic                          ack_valid_o,
  output logic [pcie_rx_pkg::SEQ_W-1:0] ack_seq_o,
  input  wire                           ack_ready_i
);
  import pcie_rx_pkg::*;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SEQ,
    ST_PAYLOAD,
    ST_DECIDE,
    ST_ACK
  } state_e;

  state_e           state_r;
  state_e           state_next;
  logic [SEQ_W-1:0] frame_seq_r;
  logic [SEQ_W-1:0] ack_seq_r;
  logic             take;
  rx_verdict_e      verdict;

  assign take      = beat_valid_i && beat_ready_o;
  assign wr_data_o = beat_i.data;
  assign ack_seq_o = ack_seq_r;

  // length first, then LCRC, then sequence number
  always_comb begin
    if (oversize_i || !crc_match_i) begin
      verdict = VERDICT_DROP;
    end else if (frame_seq_r != expected_seq_i) begin
      verdict = VERDICT_DUPLICATE;
    end else begin
      verdict = VERDICT_ACCEPT;
    end
  end

  always_comb begin
    state_next    = state_r;
    beat_ready_o  = 1'b0;
    wr_en_o       = 1'b0;
    commit_o      = 1'b0;
    discard_o     = 1'b0;
    crc_clear_o   = 1'b0;
    crc_step_o    = 1'b0;
    word_clear_o  = 1'b0;
    word_step_o   = 1'b0;
    seq_advance_o = 1'b0;
    ack_valid_o   = 1'b0;
    case (state_r)
      ST_IDLE: begin
        crc_clear_o  = 1'b1;
        word_clear_o = 1'b1;
        state_next   = ST_SEQ;
      end
      ST_SEQ: begin
        beat_ready_o = link_active_i && slot_free_i;
        crc_step_o   = take;
        if (take) begin
          state_next = ST_PAYLOAD;
        end
      end
      ST_PAYLOAD: begin
        // the LCRC beat is left waiting for the decide cycle
        beat_ready_o = link_active_i && slot_free_i && !beat_i.last;
        crc_step_o   = take;
        word_step_o  = take;
        wr_en_o      = take && !oversize_i;
        if (beat_valid_i && beat_i.last) begin
          state_next = ST_DECIDE;
        end
      end
      ST_DECIDE: begin
        beat_ready_o  = 1'b1;
        commit_o      = (verdict == VERDICT_ACCEPT);
        discard_o     = (verdict != VERDICT_ACCEPT);
        seq_advance_o = (verdict == VERDICT_ACCEPT);
        state_next    = (verdict == VERDICT_DROP) ? ST_IDLE : ST_ACK;
      end
      ST_ACK: begin
        ack_valid_o = 1'b1;
        if (ack_ready_i) begin
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= ST_IDLE;
    end else begin
      state_r <= state_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == ST_SEQ && take) begin
      frame_seq_r <= beat_i.data[SEQ_W-1:0];
    end
    // a duplicate is answered with the last good number
    if (state_r == ST_DECIDE) begin
      ack_seq_r <= (verdict == VERDICT_ACCEPT) ? frame_seq_r : expected_seq_i - SEQ_W'(1);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/rx_tlp_buffer.sv ====
// slotted receive buffer, one TLP per slot
// commit or discard on the write side, streaming read to the transaction layer
`default_nettype none

module rx_tlp_buffer #(
  parameter int NUM_SLOTS  = 4,
  parameter int MAX_TLP_DW = 16
) (
  input  wire                           clk_i,
  input  wire                           rst_i,
  input  wire                           wr_en_i,
  input  wire [pcie_rx_pkg::DATA_W-1:0] wr_data_i,
  input  wire                           commit_i,
  input  wire                           discard_i,
  output logic                          slot_free_o,
  output pcie_rx_pkg::stream_beat_t     tlp_beat_o,
  output logic                          tlp_valid_o,
  input  wire                           tlp_ready_i
);
  import pcie_rx_pkg::*;

  localparam int SLOT_W = $clog2(NUM_SLOTS);
  localparam int OFF_W  = $clog2(MAX_TLP_DW + 1);
  localparam int DEPTH  = NUM_SLOTS * MAX_TLP_DW;
  localparam int ADDR_W = $clog2(DEPTH);

  logic [DATA_W-1:0] data_mem [DEPTH];
  logic [OFF_W-1:0]  len_mem  [NUM_SLOTS];

  // slot pointers carry a wrap bit
  logic [SLOT_W:0]   tail_r;
  logic [SLOT_W:0]   head_r;
  logic [OFF_W-1:0]  wr_off_r;
  logic [OFF_W-1:0]  rd_off_r;
  logic [OFF_W-1:0]  head_len;
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;
  logic              wr_ok;
  logic              load;
  logic              load_last;
  logic [DATA_W-1:0] rd_data_r;
  logic              rd_last_r;

  assign slot_free_o = ((tail_r ^ head_r) != {1'b1, {SLOT_W{1'b0}}});
  assign wr_ok       = wr_en_i && (wr_off_r < OFF_W'(MAX_TLP_DW));
  assign wr_addr     = ADDR_W'(tail_r[SLOT_W-1:0] * MAX_TLP_DW + wr_off_r);
  assign rd_addr     = ADDR_W'(head_r[SLOT_W-1:0] * MAX_TLP_DW + rd_off_r);
  assign head_len    = len_mem[head_r[SLOT_W-1:0]];

  // fetch the next word when a slot is committed and the output can move
  assign load      = (head_r != tail_r) && (!tlp_valid_o || tlp_ready_i);
  assign load_last = (rd_off_r + OFF_W'(1) >= head_len);

  assign tlp_beat_o = '{data: rd_data_r, last: rd_last_r};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tail_r   <= '0;
      wr_off_r <= '0;
    end else if (commit_i) begin
      tail_r   <= tail_r + 1'b1;
      wr_off_r <= '0;
    end else if (discard_i) begin
      wr_off_r <= '0;
    end else if (wr_ok) begin
      wr_off_r <= wr_off_r + 1'b1;
    end
  end

  // slot is released once its final word sits in the output register
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      head_r      <= '0;
      rd_off_r    <= '0;
      tlp_valid_o <= 1'b0;
    end else if (load) begin
      tlp_valid_o <= 1'b1;
      if (load_last) begin
        rd_off_r <= '0;
        head_r   <= head_r + 1'b1;
      end else begin
        rd_off_r <= rd_off_r + 1'b1;
      end
    end else if (tlp_ready_i) begin
      tlp_valid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_ok) begin
      data_mem[wr_addr] <= wr_data_i;
    end
    if (commit_i) begin
      len_mem[tail_r[SLOT_W-1:0]] <= wr_off_r;
    end
    if (load) begin
      rd_data_r <= data_mem[rd_addr];
      rd_last_r <= load_last;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ack_dllp_tx.sv ====
// Ack DLLP sender
// type and sequence beat, then the CRC-16 beat
`default_nettype none

module ack_dllp_tx (
  input  wire                          clk_i,
  input  wire                          rst_i,
  input  wire                          ack_valid_i,
  input  wire [pcie_rx_pkg::SEQ_W-1:0] ack_seq_i,
  output logic                         ack_ready_o,
  output pcie_rx_pkg::dllp_beat_t      dllp_beat_o,
  output logic                         dllp_valid_o,
  input  wire                          dllp_ready_i
);
  import pcie_rx_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_BEAT0,
    ST_BEAT1
  } state_e;

  state_e            state_r;
  logic [DATA_W-1:0] word0_next;
  logic [DATA_W-1:0] word0_r;
  logic [15:0]       crc_r;

  function automatic logic [15:0] dllp_crc(input logic [DATA_W-1:0] word);
    logic [15:0] c;
    c = '1;
    for (int i = DATA_W - 1; i >= 0; i--) begin
      c = {c[14:0], 1'b0} ^ ((c[15] ^ word[i]) ? DLLP_CRC_POLY : '0);
    end
    return ~c;
  endfunction

  assign word0_next = {DLLP_TYPE_ACK, {(DATA_W - 8 - SEQ_W){1'b0}}, ack_seq_i};

  assign dllp_valid_o     = (state_r != ST_IDLE);
  assign dllp_beat_o.data = (state_r == ST_BEAT1) ? {16'h0000, crc_r} : word0_r;
  assign dllp_beat_o.keep = (state_r == ST_BEAT1) ? 4'b0011 : 4'b1111;
  assign dllp_beat_o.last = (state_r == ST_BEAT1);
  assign ack_ready_o      = (state_r == ST_BEAT1) && dllp_ready_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_r <= ST_IDLE;
    end else begin
      case (state_r)
        ST_IDLE: begin
          if (ack_valid_i) begin
            state_r <= ST_BEAT0;
          end
        end
        ST_BEAT0: begin
          if (dllp_ready_i) begin
            state_r <= ST_BEAT1;
          end
        end
        ST_BEAT1: begin
          if (dllp_ready_i) begin
            state_r <= ST_IDLE;
          end
        end
        default: begin
          state_r <= ST_IDLE;
        end
      endcase
    end
  end

  // request is latched once, the FSM holds it until ack_ready_o
  always_ff @(posedge clk_i) begin
    if (state_r == ST_IDLE && ack_valid_i) begin
      word0_r <= word0_next;
      crc_r   <= dllp_crc(word0_next);
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pcie_dll_rx.sv ====
// receive side of the PCIe data link layer
// input skid, frame FSM, LCRC check, receive buffer and Ack sender
`default_nettype none

module pcie_dll_rx #(
  parameter int NUM_SLOTS  = 4,
  parameter int MAX_TLP_DW = 16
) (
  input  wire                           clk_i,
  input  wire                           rst_i,
  input  wire                           link_active_i,
  input  wire pcie_rx_pkg::stream_beat_t rx_beat_i,
  input  wire                           rx_valid_i,
  output logic                          rx_ready_o,
  output pcie_rx_pkg::stream_beat_t     tlp_beat_o,
  output logic                          tlp_valid_o,
  input  wire                           tlp_ready_i,
  output pcie_rx_pkg::dllp_beat_t       dllp_beat_o,
  output logic                          dllp_valid_o,
  input  wire                           dllp_ready_i
);
  import pcie_rx_pkg::*;

  // skid output to the FSM
  stream_beat_t     in_beat;
  logic             in_valid;
  logic             in_ready;

  // Ack sender to the output skid
  dllp_beat_t       ack_beat;
  logic             ack_beat_valid;
  logic             ack_beat_ready;

  logic             wr_en;
  logic [DATA_W-1:0] wr_data;
  logic             commit;
  logic             discard;
  logic             slot_free;
  logic             crc_clear;
  logic             crc_step;
  logic             crc_match;
  logic             word_clear;
  logic             word_step;
  logic             seq_advance;
  logic             oversize;
  logic [SEQ_W-1:0] expected_seq;
  logic             ack_valid;
  logic [SEQ_W-1:0] ack_seq;
  logic             ack_ready;

  axis_skid_buffer #(
    .payload_t(stream_beat_t)
  ) rx_skid_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .s_beat_i (rx_beat_i),
    .s_valid_i(rx_valid_i),
    .s_ready_o(rx_ready_o),
    .m_beat_o (in_beat),
    .m_valid_o(in_valid),
    .m_ready_i(in_ready)
  );

  dll_rx_fsm dll_rx_fsm_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .link_active_i (link_active_i),
    .beat_i        (in_beat),
    .beat_valid_i  (in_valid),
    .beat_ready_o  (in_ready),
    .slot_free_i   (slot_free),
    .wr_en_o       (wr_en),
    .wr_data_o     (wr_data),
    .commit_o      (commit),
    .discard_o     (discard),
    .crc_clear_o   (crc_clear),
    .crc_step_o    (crc_step),
    .crc_match_i   (crc_match),
    .word_clear_o  (word_clear),
    .word_step_o   (word_step),
    .seq_advance_o (seq_advance),
    .oversize_i    (oversize),
    .expected_seq_i(expected_seq),
    .ack_valid_o   (ack_valid),
    .ack_seq_o     (ack_seq),
    .ack_ready_i   (ack_ready)
  );

  lcrc_checker lcrc_checker_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .crc_clear_i(crc_clear),
    .crc_step_i (crc_step),
    .word_i     (in_beat.data),
    .crc_match_o(crc_match)
  );

  rx_frame_counter #(
    .MAX_TLP_DW(MAX_TLP_DW)
  ) rx_frame_counter_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .word_clear_i  (word_clear),
    .word_step_i   (word_step),
    .seq_advance_i (seq_advance),
    .oversize_o    (oversize),
    .expected_seq_o(expected_seq)
  );

  rx_tlp_buffer #(
    .NUM_SLOTS (NUM_SLOTS),
    .MAX_TLP_DW(MAX_TLP_DW)
  ) rx_tlp_buffer_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .wr_en_i    (wr_en),
    .wr_data_i  (wr_data),
    .commit_i   (commit),
    .discard_i  (discard),
    .slot_free_o(slot_free),
    .tlp_beat_o (tlp_beat_o),
    .tlp_valid_o(tlp_valid_o),
    .tlp_ready_i(tlp_ready_i)
  );

  ack_dllp_tx ack_dllp_tx_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .ack_valid_i (ack_valid),
    .ack_seq_i   (ack_seq),
    .ack_ready_o (ack_ready),
    .dllp_beat_o (ack_beat),
    .dllp_valid_o(ack_beat_valid),
    .dllp_ready_i(ack_beat_ready)
  );

  axis_skid_buffer #(
    .payload_t(dllp_beat_t)
  ) dllp_skid_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .s_beat_i (ack_beat),
    .s_valid_i(ack_beat_valid),
    .s_ready_o(ack_beat_ready),
    .m_beat_o (dllp_beat_o),
    .m_valid_o(dllp_valid_o),
    .m_ready_i(dllp_ready_i)
  );

endmodule

`default_nettype wire

// ==== dv/pcie_dll_rx_tb.sv ====
// testbench for the receive data link layer
// frame stimulus, reference model for TLPs and Acks, output scoreboard, timeout
`default_nettype none

module pcie_dll_rx_tb;
  import pcie_rx_pkg::*;

  localparam int NUM_SLOTS  = 4;
  localparam int MAX_TLP_DW = 16;

  logic         clk_i;
  logic         rst_i;
  logic         link_active_i;
  stream_beat_t rx_beat_i;
  logic         rx_valid_i;
  logic         rx_ready_o;
  stream_beat_t tlp_beat_o;
  logic         tlp_valid_o;
  logic         tlp_ready_i = 1'b1;
  dllp_beat_t   dllp_beat_o;
  logic         dllp_valid_o;
  logic         dllp_ready_i = 1'b1;

  // 0 always ready, 1 random, 2 held low
  logic [1:0]   tlp_mode = 2'd0;
  logic [1:0]   dllp_mode = 2'd0;
  logic [31:0]  stim_rng = 32'h55a2101c;
  logic [31:0]  ready_rng = 32'h55a2101c;
  logic [11:0]  ref_seq = 12'h000;
  int           beats_taken = 0;
  int           cycle_cnt = 0;
  stream_beat_t exp_tlp_q[$];
  dllp_beat_t   exp_dllp_q[$];

  pcie_dll_rx #(
    .NUM_SLOTS (NUM_SLOTS),
    .MAX_TLP_DW(MAX_TLP_DW)
  ) pcie_dll_rx_i (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .link_active_i(link_active_i),
    .rx_beat_i    (rx_beat_i),
    .rx_valid_i   (rx_valid_i),
    .rx_ready_o   (rx_ready_o),
    .tlp_beat_o   (tlp_beat_o),
    .tlp_valid_o  (tlp_valid_o),
    .tlp_ready_i  (tlp_ready_i),
    .dllp_beat_o  (dllp_beat_o),
    .dllp_valid_o (dllp_valid_o),
    .dllp_ready_i (dllp_ready_i)
  );

  always #2 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // CRC-32 over all words before the LCRC, msb first, inverted
  function automatic logic [31:0] lcrc_ref(input logic [31:0] words[$]);
    logic [31:0] crc;
    logic        fb;
    crc = 32'hFFFF_FFFF;
    foreach (words[w]) begin
      for (int b = 31; b >= 0; b--) begin
        fb  = crc[31] ^ words[w][b];
        crc = crc << 1;
        if (fb) begin
          crc = crc ^ 32'h04C1_1DB7;
        end
      end
    end
    return ~crc;
  endfunction

  function automatic logic [15:0] dllp_crc_ref(input logic [31:0] word);
    logic [15:0] crc;
    logic        fb;
    crc = 16'hFFFF;
    for (int b = 31; b >= 0; b--) begin
      fb  = crc[15] ^ word[b];
      crc = crc << 1;
      if (fb) begin
        crc = crc ^ 16'h100B;
      end
    end
    return ~crc;
  endfunction

  function automatic void push_ack(input logic [11:0] seq);
    logic [31:0] word0;
    word0 = {8'h00, 12'h000, seq};
    exp_dllp_q.push_back('{data: word0, keep: 4'b1111, last: 1'b0});
    exp_dllp_q.push_back('{data: {16'h0000, dllp_crc_ref(word0)}, keep: 4'b0011, last: 1'b1});
  endfunction

  // oversize and bad LCRC frames leave no trace
  function automatic void model_frame(input logic [31:0] words[$], input logic [31:0] lcrc);
    int          n_dw;
    logic [11:0] seq;
    n_dw = words.size() - 1;
    seq  = words[0][11:0];
    if (n_dw <= MAX_TLP_DW && lcrc == lcrc_ref(words)) begin
      if (seq == ref_seq) begin
        for (int i = 1; i <= n_dw; i++) begin
          exp_tlp_q.push_back('{data: words[i], last: (i == n_dw)});
        end
        push_ack(seq);
        ref_seq = ref_seq + 12'd1;
      end else begin
        push_ack(ref_seq - 12'd1);
      end
    end
  endfunction

  function automatic int rand_len(input int max_len);
    stim_rng = lcg_next(stim_rng);
    return 1 + int'(stim_rng[31:20]) % max_len;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic value_error(input string name, input logic [63:0] got, input logic [63:0] exp);
    abort_run($sformatf("Fail at time %0t: %s is %0h, expected %0h", $time, name, got, exp));
  endtask

  // called a little after a rising edge, returns at the same point
  task automatic drive_beat(input logic [31:0] data, input logic last);
    logic done;
    rx_beat_i  = '{data: data, last: last};
    rx_valid_i = 1'b1;
    done       = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = rx_ready_o;
      @(posedge clk_i);
      #1;
    end
    beats_taken++;
  endtask

  task automatic send_frame(input logic [11:0] seq, input int n_dw, input logic corrupt);
    logic [31:0] words[$];
    logic [31:0] lcrc;
    words.push_back({20'h00000, seq});
    for (int i = 0; i < n_dw; i++) begin
      stim_rng = lcg_next(stim_rng);
      words.push_back(stim_rng);
    end
    lcrc = lcrc_ref(words);
    if (corrupt) begin
      lcrc = lcrc ^ 32'h0001_0000;
    end
    model_frame(words, lcrc);
    foreach (words[i]) begin
      drive_beat(words[i], 1'b0);
    end
    drive_beat(lcrc, 1'b1);
    rx_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_tlp_q.size() != 0 || exp_dllp_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (20) @(posedge clk_i);
    #1;
  endtask

  task automatic check_stalled(input int base, input int max_beats);
    repeat (300) @(posedge clk_i);
    @(negedge clk_i);
    assert (rx_ready_o == 1'b0) else value_error("rx_ready_o", 64'(rx_ready_o), 64'd0);
    assert (beats_taken - base <= max_beats) else abort_run("input kept taking beats in a stall");
    @(posedge clk_i);
    #1;
  endtask

  always @(posedge clk_i) begin
    #1;
    ready_rng    = lcg_next(ready_rng);
    tlp_ready_i  = (tlp_mode == 2'd0) || (tlp_mode == 2'd1 && ready_rng[31:30] != 2'b00);
    dllp_ready_i = (dllp_mode == 2'd0) || (dllp_mode == 2'd1 && ready_rng[27]);
  end

  // limit grows with the words sent so far
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > 40 * beats_taken + 2000) begin
      abort_run($sformatf("timeout, no progress after %0d cycles", cycle_cnt));
    end
  end

  // scoreboard, outputs are stable at the falling edge
  always @(negedge clk_i) begin
    stream_beat_t exp_tlp;
    dllp_beat_t   exp_dllp;
    if (!rst_i && tlp_valid_o && tlp_ready_i) begin
      assert (exp_tlp_q.size() != 0) else abort_run("TLP beat came out with none expected");
      exp_tlp = exp_tlp_q.pop_front();
      assert (tlp_beat_o.data == exp_tlp.data)
        else value_error("tlp_beat_o.data", 64'(tlp_beat_o.data), 64'(exp_tlp.data));
      assert (tlp_beat_o.last == exp_tlp.last)
        else value_error("tlp_beat_o.last", 64'(tlp_beat_o.last), 64'(exp_tlp.last));
    end
    if (!rst_i && dllp_valid_o && dllp_ready_i) begin
      assert (exp_dllp_q.size() != 0) else abort_run("DLLP beat came out with no Ack expected");
      exp_dllp = exp_dllp_q.pop_front();
      assert (dllp_beat_o.data == exp_dllp.data)
        else value_error("dllp_beat_o.data", 64'(dllp_beat_o.data), 64'(exp_dllp.data));
      assert (dllp_beat_o.keep == exp_dllp.keep)
        else value_error("dllp_beat_o.keep", 64'(dllp_beat_o.keep), 64'(exp_dllp.keep));
      assert (dllp_beat_o.last == exp_dllp.last)
        else value_error("dllp_beat_o.last", 64'(dllp_beat_o.last), 64'(exp_dllp.last));
    end
  end

  initial begin
    int base;
    clk_i         = 1'b0;
    rst_i         = 1'b1;
    link_active_i = 1'b1;
    rx_valid_i    = 1'b0;
    rx_beat_i     = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_i = 1'b0;

    // in-order good frames
    repeat (12) send_frame(ref_seq, rand_len(MAX_TLP_DW), 1'b0);
    wait_drain();

    // bad LCRC, then the expected number again
    repeat (3) begin
      send_frame(ref_seq, rand_len(MAX_TLP_DW), 1'b1);
      send_frame(ref_seq, rand_len(MAX_TLP_DW), 1'b0);
    end
    wait_drain();

    // replayed old numbers
    repeat (3) begin
      stim_rng = lcg_next(stim_rng);
      send_frame(ref_seq - 12'd1 - 12'(stim_rng[31:30]), rand_len(4), 1'b0);
    end
    send_frame(ref_seq, rand_len(MAX_TLP_DW), 1'b0);
    wait_drain();

    // too long with a good LCRC
    send_frame(ref_seq, MAX_TLP_DW + 1, 1'b0);
    send_frame(ref_seq, MAX_TLP_DW + 5, 1'b0);
    send_frame(ref_seq, MAX_TLP_DW, 1'b0);
    wait_drain();

    // random stalls on both outputs
    tlp_mode  = 2'd1;
    dllp_mode = 2'd1;
    repeat (40) send_frame(ref_seq, rand_len(3), 1'b0);
    wait_drain();

    // TLP output held, the buffer fills and the input stops
    tlp_mode  = 2'd2;
    dllp_mode = 2'd0;
    base      = beats_taken;
    fork
      repeat (NUM_SLOTS + 2) send_frame(ref_seq, 2, 1'b0);
      begin
        check_stalled(base, NUM_SLOTS * 4 + 2);
        tlp_mode = 2'd0;
      end
    join
    wait_drain();

    // link down, at most the input skid fills
    link_active_i = 1'b0;
    base          = beats_taken;
    fork
      send_frame(ref_seq, 3, 1'b0);
      begin
        check_stalled(base, 2);
        link_active_i = 1'b1;
      end
    join
    repeat (2) send_frame(ref_seq, rand_len(MAX_TLP_DW), 1'b0);
    wait_drain();

    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/pcie_rx_pkg.sv
rtl/axis_skid_buffer.sv
rtl/lcrc_checker.sv
rtl/rx_frame_counter.sv
rtl/dll_rx_fsm.sv
rtl/rx_tlp_buffer.sv
rtl/ack_dllp_tx.sv
rtl/pcie_dll_rx.sv
dv/pcie_dll_rx_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# compile and run the receive data link layer testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -j 0 --top-module pcie_dll_rx_tb -f list.f
./obj_dir/Vpcie_dll_rx_tb
